// File: verilog/ib_pkg.sv
// four-entry buffer only; pc carried as bits 31:1, debug address cut to 12 bits
package ib_pkg;

   // buffer geometry
   localparam int IB_DEPTH = 4;      // slot 0 is the oldest entry

   // field widths
   localparam int PC_W = 31;         // pc[31:1], bit 0 is implied zero
   localparam int INST_W = 32;       // full 32b word, compressed already expanded

   // debug command address
   // only the low bits reach the synthesized instruction
   //   gpr commands use bits 4:0
   //   csr commands use bits 11:0
   localparam int DBG_ADDR_W = 12;

endpackage

// File: verilog/rv_instr_pkg.sv
// only the OR and CSR formats needed for debug injection; debug types 2 and 3 are not decoded
package rv_instr_pkg;

   // major opcodes
   localparam logic [6:0] OPCODE_OP = 7'b0110011;
   localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

   // funct3 values
   localparam logic [2:0] FUNCT3_OR = 3'b110;
   localparam logic [2:0] FUNCT3_CSRRW = 3'b001;
   localparam logic [2:0] FUNCT3_CSRRS = 3'b010;

   // debug abstract command types
   localparam logic [1:0] DBG_TYPE_GPR = 2'd0;
   localparam logic [1:0] DBG_TYPE_CSR = 2'd1;   // memory access (2) is handled elsewhere

   // fence csr, writable only in debug mode
   localparam logic [11:0] CSR_DEBUG_FENCE = 12'h7c4;

   // one instruction word seen as R-type or as a csr access
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] csr;    // csr address takes the funct7/rs2 field
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } csr;
   } rv_instr_u;

endpackage

// File: verilog/ib_ctl_if.sv
// slot controls are valid in the cycle they are computed; no clock travels on this bundle
`timescale 1ns/100ps

interface ib_ctl_if;

   logic [ib_pkg::IB_DEPTH-1:0] wr_i0;     // i0 (or debug) lands in this slot
   logic [ib_pkg::IB_DEPTH-1:1] wr_i1;     // i1 never lands in slot 0
   logic                        shift1;    // decode retires one
   logic                        shift2;    // decode retires two
   logic [ib_pkg::IB_DEPTH-1:0] slot_we;   // per-slot load enable
   logic                        flush_q;   // registered flush

   modport ctl (
      output wr_i0, wr_i1, shift1, shift2, slot_we, flush_q
   );

   modport entries (
      input wr_i0, wr_i1, shift1, shift2, slot_we
   );

   modport status (
      input slot_we
   );

endinterface

// File: verilog/dbg_inj_if.sv
// debug entry is combinational from the command inputs; valid only while the core is halted
`timescale 1ns/100ps

interface dbg_inj_if;

   logic                    valid;       // gpr or csr command this cycle
   rv_instr_pkg::rv_instr_u inst;        // synthesized instruction word
   logic                    wdata_rs1;   // rs1 replaced by debug write data
   logic                    fence;       // write to the debug fence csr

   modport gen (output valid, inst, wdata_rs1, fence);

   modport ctl (input valid);

   modport entries (input valid, inst);

   modport status (input valid, wdata_rs1, fence);

endinterface

// File: verilog/dbg_instr_gen.sv
// gpr and csr commands only; other types leave valid low and the instruction word unused
`timescale 1ns/100ps

module dbg_instr_gen (
   input  logic                          dbg_cmd_valid,
   input  logic                          dbg_cmd_write,
   input  logic [1:0]                    dbg_cmd_type,
   input  logic [ib_pkg::DBG_ADDR_W-1:0] dbg_cmd_addr,
   dbg_inj_if.gen                        dbg_if
);

   logic                    is_gpr;
   logic                    is_csr;
   rv_instr_pkg::rv_instr_u inst;

   assign is_gpr = dbg_cmd_type == rv_instr_pkg::DBG_TYPE_GPR;
   assign is_csr = dbg_cmd_type == rv_instr_pkg::DBG_TYPE_CSR;

   // gpr read:  or x0, reg, x0     gpr write: or reg, x0, x0
   // csr read:  csrrs x0, csr, x0  csr write: csrrw x0, csr, x0
   always_comb begin
      inst = '0;
      if (is_gpr) begin
         inst.r.opcode = rv_instr_pkg::OPCODE_OP;
         inst.r.funct3 = rv_instr_pkg::FUNCT3_OR;
         if (dbg_cmd_write) begin
            inst.r.rd = dbg_cmd_addr[4:0];    // write data arrives on rs1
         end else begin
            inst.r.rs1 = dbg_cmd_addr[4:0];
         end
      end else if (is_csr) begin
         inst.csr.opcode = rv_instr_pkg::OPCODE_SYSTEM;
         inst.csr.csr = dbg_cmd_addr;
         inst.csr.funct3 = dbg_cmd_write ? rv_instr_pkg::FUNCT3_CSRRW
                                         : rv_instr_pkg::FUNCT3_CSRRS;
      end
   end

   assign dbg_if.valid = dbg_cmd_valid & (is_gpr | is_csr);
   assign dbg_if.inst = inst;
   assign dbg_if.wdata_rs1 = dbg_if.valid & dbg_cmd_write;
   assign dbg_if.fence = dbg_if.valid & is_csr & dbg_cmd_write &
                         (dbg_cmd_addr == rv_instr_pkg::CSR_DEBUG_FENCE);

endmodule

// File: verilog/ib_ctl.sv
// aligner must hold i1 valid only with i0 valid; decode must not retire past ib_valid
`timescale 1ns/100ps

module ib_ctl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        ifu_i0_valid,
   input  logic                        ifu_i1_valid,
   input  logic                        dec_i0_decode,
   input  logic                        dec_i1_decode,
   input  logic                        flush,
   dbg_inj_if.ctl                      dbg_if,
   ib_ctl_if.ctl                       ctl_if,
   output logic [ib_pkg::IB_DEPTH-1:0] ib_valid
);

   logic                          flush_q;
   logic [ib_pkg::IB_DEPTH-1:0]   val_q;
   logic [ib_pkg::IB_DEPTH-1:0]   val_nxt;
   logic [ib_pkg::IB_DEPTH-1:0]   shift_val;
   logic [ib_pkg::IB_DEPTH+1:0]   val_ext;
   logic [ib_pkg::IB_DEPTH-1:0]   wr_i0;
   logic [ib_pkg::IB_DEPTH-1:1]   wr_i1;
   logic [ib_pkg::IB_DEPTH-1:0]   wr_i1_all;
   logic [ib_pkg::IB_DEPTH-1:0]   slot_we;
   logic                          i0_acc;
   logic                          i1_acc;
   logic                          shift1;
   logic                          shift2;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flush_q <= 1'b0;
         val_q <= '0;
      end else begin
         flush_q <= flush;
         val_q <= val_nxt;
      end
   end

   // room check uses the registered vector, no decode bypass
   assign i0_acc = ifu_i0_valid & ~val_q[ib_pkg::IB_DEPTH-1] & ~flush_q;
   assign i1_acc = ifu_i1_valid & ~val_q[ib_pkg::IB_DEPTH-2] & ~flush_q;

   assign shift1 = dec_i0_decode ^ dec_i1_decode;
   assign shift2 = dec_i0_decode & dec_i1_decode;

   // where the entries sit after this cycle's retirement
   assign shift_val = shift2 ? (val_q >> 2) : shift1 ? (val_q >> 1) : val_q;
   assign val_ext = {2'b00, val_q};

   always_comb begin
      wr_i0 = '0;
      wr_i1 = '0;
      wr_i0[0] = ~shift_val[0] & (i0_acc | dbg_if.valid);   // debug only into an empty buffer
      for (int k = 1; k < ib_pkg::IB_DEPTH; k++) begin
         wr_i0[k] = shift_val[k-1] & ~shift_val[k] & i0_acc;
      end
      wr_i1[1] = ~shift_val[0] & i1_acc;
      for (int k = 2; k < ib_pkg::IB_DEPTH; k++) begin
         wr_i1[k] = shift_val[k-2] & ~shift_val[k-1] & i1_acc;   // one above i0
      end
   end

   assign wr_i1_all = {wr_i1, 1'b0};

   always_comb begin
      for (int k = 0; k < ib_pkg::IB_DEPTH; k++) begin
         slot_we[k] = wr_i0[k] | wr_i1_all[k] |
                      (shift1 & val_ext[k+1]) | (shift2 & val_ext[k+2]);
      end
   end

   assign val_nxt = (shift_val | wr_i0 | wr_i1_all) & ~{ib_pkg::IB_DEPTH{flush_q}};

   assign ctl_if.wr_i0 = wr_i0;
   assign ctl_if.wr_i1 = wr_i1;
   assign ctl_if.shift1 = shift1;
   assign ctl_if.shift2 = shift2;
   assign ctl_if.slot_we = slot_we;
   assign ctl_if.flush_q = flush_q;
   assign ib_valid = val_q;

endmodule

// File: verilog/ib_entries.sv
// entry data is not reset; only slots marked in ib_valid hold meaningful contents
`timescale 1ns/100ps

module ib_entries (
   input  logic                        clk,
   input  logic [ib_pkg::INST_W-1:0]   ifu_i0_inst,
   input  logic [ib_pkg::PC_W-1:0]     ifu_i0_pc,
   input  logic                        ifu_i0_pc4,
   input  logic [ib_pkg::INST_W-1:0]   ifu_i1_inst,
   input  logic [ib_pkg::PC_W-1:0]     ifu_i1_pc,
   input  logic                        ifu_i1_pc4,
   ib_ctl_if.entries                   ctl_if,
   dbg_inj_if.entries                  dbg_if,
   output logic [ib_pkg::INST_W-1:0]   i0_inst,
   output logic [ib_pkg::PC_W-1:0]     i0_pc,
   output logic                        i0_pc4,
   output logic [ib_pkg::INST_W-1:0]   i1_inst,
   output logic [ib_pkg::PC_W-1:0]     i1_pc,
   output logic                        i1_pc4
);

   logic [ib_pkg::INST_W-1:0] inst_q [ib_pkg::IB_DEPTH];
   logic [ib_pkg::PC_W-1:0]   pc_q [ib_pkg::IB_DEPTH];
   logic [ib_pkg::IB_DEPTH-1:0] pc4_q;
   logic [ib_pkg::INST_W-1:0] inst_d [ib_pkg::IB_DEPTH];
   logic [ib_pkg::PC_W-1:0]   pc_d [ib_pkg::IB_DEPTH];
   logic [ib_pkg::IB_DEPTH-1:0] pc4_d;
   logic [ib_pkg::INST_W-1:0] inst_ext [ib_pkg::IB_DEPTH+2];   // two empty slots above the top
   logic [ib_pkg::PC_W-1:0]   pc_ext [ib_pkg::IB_DEPTH+2];
   logic [ib_pkg::IB_DEPTH+1:0] pc4_ext;
   logic [ib_pkg::IB_DEPTH-1:0] wr_i1_all;

   assign wr_i1_all = {ctl_if.wr_i1, 1'b0};
   assign pc4_ext = {2'b00, pc4_q};

   always_comb begin
      for (int k = 0; k < ib_pkg::IB_DEPTH; k++) begin
         inst_ext[k] = inst_q[k];
         pc_ext[k] = pc_q[k];
      end
      inst_ext[ib_pkg::IB_DEPTH] = '0;
      inst_ext[ib_pkg::IB_DEPTH+1] = '0;
      pc_ext[ib_pkg::IB_DEPTH] = '0;
      pc_ext[ib_pkg::IB_DEPTH+1] = '0;
   end

   // writes win over shifts; a written slot is empty after the shift
   always_comb begin
      for (int k = 0; k < ib_pkg::IB_DEPTH; k++) begin
         if (k == 0 && dbg_if.valid) begin
            inst_d[k] = dbg_if.inst;   // synthesized debug op, no pc
            pc_d[k] = '0;
            pc4_d[k] = 1'b0;
         end else if (ctl_if.wr_i0[k]) begin
            inst_d[k] = ifu_i0_inst;
            pc_d[k] = ifu_i0_pc;
            pc4_d[k] = ifu_i0_pc4;
         end else if (wr_i1_all[k]) begin
            inst_d[k] = ifu_i1_inst;
            pc_d[k] = ifu_i1_pc;
            pc4_d[k] = ifu_i1_pc4;
         end else if (ctl_if.shift2) begin
            inst_d[k] = inst_ext[k+2];
            pc_d[k] = pc_ext[k+2];
            pc4_d[k] = pc4_ext[k+2];
         end else begin
            inst_d[k] = inst_ext[k+1];
            pc_d[k] = pc_ext[k+1];
            pc4_d[k] = pc4_ext[k+1];
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < ib_pkg::IB_DEPTH; k++) begin
         if (ctl_if.slot_we[k]) begin
            inst_q[k] <= inst_d[k];
            pc_q[k] <= pc_d[k];
            pc4_q[k] <= pc4_d[k];
         end
      end
   end

   assign i0_inst = inst_q[0];
   assign i0_pc = pc_q[0];
   assign i0_pc4 = pc4_q[0];
   assign i1_inst = inst_q[1];
   assign i1_pc = pc_q[1];
   assign i1_pc4 = pc4_q[1];

endmodule

// File: verilog/dbg_status.sv
// flags follow slot 0 only; debug_wdata_rs1 and debug_fence are not qualified by slot 0 valid
`timescale 1ns/100ps

module dbg_status (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     ib0_valid,
   ib_ctl_if.status ctl_if,
   dbg_inj_if.status dbg_if,
   output logic     debug_wdata_rs1,
   output logic     debug_fence,
   output logic     i0_debug_valid
);

   logic dbg_q;
   logic wdata_q;
   logic fence_q;

   // a normal entry loading slot 0 brings zeros along
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbg_q <= 1'b0;
         wdata_q <= 1'b0;
         fence_q <= 1'b0;
      end else if (ctl_if.slot_we[0]) begin
         dbg_q <= dbg_if.valid;
         wdata_q <= dbg_if.wdata_rs1;
         fence_q <= dbg_if.fence;
      end
   end

   assign debug_wdata_rs1 = wdata_q;
   assign debug_fence = fence_q;
   assign i0_debug_valid = dbg_q & ib0_valid;   // stale flag after retirement masked

endmodule

// File: verilog/ib_top.sv
// debug commands only while halted with an empty buffer; refused fetches must be re-offered
`timescale 1ns/100ps

module ib_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          ifu_i0_valid,
   input  logic [ib_pkg::INST_W-1:0]     ifu_i0_inst,
   input  logic [ib_pkg::PC_W-1:0]       ifu_i0_pc,
   input  logic                          ifu_i0_pc4,
   input  logic                          ifu_i1_valid,
   input  logic [ib_pkg::INST_W-1:0]     ifu_i1_inst,
   input  logic [ib_pkg::PC_W-1:0]       ifu_i1_pc,
   input  logic                          ifu_i1_pc4,
   input  logic                          dec_i0_decode,
   input  logic                          dec_i1_decode,
   input  logic                          flush,
   input  logic                          dbg_cmd_valid,
   input  logic                          dbg_cmd_write,
   input  logic [1:0]                    dbg_cmd_type,
   input  logic [ib_pkg::DBG_ADDR_W-1:0] dbg_cmd_addr,
   output logic [ib_pkg::IB_DEPTH-1:0]   ib_valid,
   output logic [ib_pkg::INST_W-1:0]     i0_inst,
   output logic [ib_pkg::PC_W-1:0]       i0_pc,
   output logic                          i0_pc4,
   output logic [ib_pkg::INST_W-1:0]     i1_inst,
   output logic [ib_pkg::PC_W-1:0]       i1_pc,
   output logic                          i1_pc4,
   output logic                          debug_wdata_rs1,
   output logic                          debug_fence,
   output logic                          i0_debug_valid
);

   ib_ctl_if  ctl_if ();
   dbg_inj_if dbg_if ();

   dbg_instr_gen i_dbg_gen (
      .dbg_cmd_valid (dbg_cmd_valid),
      .dbg_cmd_write (dbg_cmd_write),
      .dbg_cmd_type  (dbg_cmd_type),
      .dbg_cmd_addr  (dbg_cmd_addr),
      .dbg_if        (dbg_if)
   );

   ib_ctl i_ctl (
      .clk           (clk),
      .rst_n         (rst_n),
      .ifu_i0_valid  (ifu_i0_valid),
      .ifu_i1_valid  (ifu_i1_valid),
      .dec_i0_decode (dec_i0_decode),
      .dec_i1_decode (dec_i1_decode),
      .flush         (flush),
      .dbg_if        (dbg_if),
      .ctl_if        (ctl_if),
      .ib_valid      (ib_valid)
   );

   ib_entries i_entries (
      .clk         (clk),
      .ifu_i0_inst (ifu_i0_inst),
      .ifu_i0_pc   (ifu_i0_pc),
      .ifu_i0_pc4  (ifu_i0_pc4),
      .ifu_i1_inst (ifu_i1_inst),
      .ifu_i1_pc   (ifu_i1_pc),
      .ifu_i1_pc4  (ifu_i1_pc4),
      .ctl_if      (ctl_if),
      .dbg_if      (dbg_if),
      .i0_inst     (i0_inst),
      .i0_pc       (i0_pc),
      .i0_pc4      (i0_pc4),
      .i1_inst     (i1_inst),
      .i1_pc       (i1_pc),
      .i1_pc4      (i1_pc4)
   );

   dbg_status i_status (
      .clk             (clk),
      .rst_n           (rst_n),
      .ib0_valid       (ib_valid[0]),
      .ctl_if          (ctl_if),
      .dbg_if          (dbg_if),
      .debug_wdata_rs1 (debug_wdata_rs1),
      .debug_fence     (debug_fence),
      .i0_debug_valid  (i0_debug_valid)
   );

endmodule

// File: tb/tb_ib_properties.sv
// bound into every ib_ctl instance; checks only hold once rst_n is released
`timescale 1ns/100ps

module tb_ib_properties (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        flush,
   input logic                        flush_q,
   input logic [ib_pkg::IB_DEPTH-1:0] val_q,
   input logic                        shift1,
   input logic                        shift2,
   input logic [ib_pkg::IB_DEPTH-1:0] slot_we
);

   // entries packed toward slot 0 with no holes
   assert property (@(posedge clk) disable iff (!rst_n) ((val_q + 1'b1) & val_q) == '0)
      else $error("valid vector not contiguous: %b", val_q);

   // flush_q one edge later and the vector cleared the edge after
   assert property (@(posedge clk) disable iff (!rst_n) flush |-> ##2 val_q == '0)
      else $error("valid vector not cleared after flush");

   // decode never retires an empty slot
   assert property (@(posedge clk) disable iff (!rst_n)
                    (!shift1 || val_q[0]) && (!shift2 || val_q[1]))
      else $error("shift retires an entry that is not valid: %b", val_q);

   // a loaded slot 0 is valid unless flush_q clears it
   assert property (@(posedge clk) disable iff (!rst_n)
                    slot_we[0] && !flush_q |=> val_q[0])
      else $error("slot 0 loaded but not marked valid");

endmodule

bind ib_ctl tb_ib_properties i_props (
   .clk     (clk),
   .rst_n   (rst_n),
   .flush   (flush),
   .flush_q (flush_q),
   .val_q   (val_q),
   .shift1  (shift1),
   .shift2  (shift2),
   .slot_we (slot_we)
);

// File: tb/tb_ib_top.sv
// directed tests and a seeded random mix; debug commands modeled only into an empty buffer
`timescale 1ns/100ps

module tb_ib_top;

   localparam int RESET_CYCLES = 16;
   localparam int RANDOM_STEPS = 400;
   // reset, five directed tests, random mix with its drain, then margin
   localparam int CYCLE_LIMIT = RESET_CYCLES + 40 + 30 + 20 + 20 + 20 + RANDOM_STEPS + 10 + 200;

   logic                          clk;
   logic                          rst_n;
   logic                          ifu_i0_valid;
   logic [ib_pkg::INST_W-1:0]     ifu_i0_inst;
   logic [ib_pkg::PC_W-1:0]       ifu_i0_pc;
   logic                          ifu_i0_pc4;
   logic                          ifu_i1_valid;
   logic [ib_pkg::INST_W-1:0]     ifu_i1_inst;
   logic [ib_pkg::PC_W-1:0]       ifu_i1_pc;
   logic                          ifu_i1_pc4;
   logic                          dec_i0_decode;
   logic                          dec_i1_decode;
   logic                          flush;
   logic                          dbg_cmd_valid;
   logic                          dbg_cmd_write;
   logic [1:0]                    dbg_cmd_type;
   logic [ib_pkg::DBG_ADDR_W-1:0] dbg_cmd_addr;
   logic [ib_pkg::IB_DEPTH-1:0]   ib_valid;
   logic [ib_pkg::INST_W-1:0]     i0_inst;
   logic [ib_pkg::PC_W-1:0]       i0_pc;
   logic                          i0_pc4;
   logic [ib_pkg::INST_W-1:0]     i1_inst;
   logic [ib_pkg::PC_W-1:0]       i1_pc;
   logic                          i1_pc4;
   logic                          debug_wdata_rs1;
   logic                          debug_fence;
   logic                          i0_debug_valid;

   // reference queue with its head in slot 0
   rv_instr_pkg::rv_instr_u     m_inst[$];
   logic [ib_pkg::PC_W-1:0]     m_pc[$];
   logic                        m_pc4[$];
   logic                        m_dbg[$];
   logic                        m_wd[$];
   logic                        m_fn[$];
   logic                        m_fq;
   int                          next_seq;
   int                          errors;
   int                          checks;
   int                          cycles;
   int                          seed;

   ib_top i_dut (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   function automatic rv_instr_pkg::rv_instr_u seq_inst(int seq);
      rv_instr_pkg::rv_instr_u w;
      w = 32'h0000_0013 | (seq << 12);   // addi pattern tagged by sequence
      return w;
   endfunction

   function automatic logic [ib_pkg::PC_W-1:0] seq_pc(int seq);
      logic [31:0] v;
      v = 32'h0000_4000 + seq * 2;
      return v[ib_pkg::PC_W-1:0];
   endfunction

   // OR words for gpr commands and CSRRS or CSRRW for csr commands
   function automatic rv_instr_pkg::rv_instr_u dbg_word(logic wr, logic [1:0] typ,
                                                        logic [11:0] addr);
      rv_instr_pkg::rv_instr_u w;
      w = '0;
      if (typ == rv_instr_pkg::DBG_TYPE_GPR) begin
         w.r.opcode = rv_instr_pkg::OPCODE_OP;
         w.r.funct3 = rv_instr_pkg::FUNCT3_OR;
         if (wr) w.r.rd = addr[4:0];
         else w.r.rs1 = addr[4:0];
      end else begin
         w.csr.opcode = rv_instr_pkg::OPCODE_SYSTEM;
         w.csr.csr = addr;
         w.csr.funct3 = wr ? rv_instr_pkg::FUNCT3_CSRRW : rv_instr_pkg::FUNCT3_CSRRS;
      end
      return w;
   endfunction

   task automatic check_inst(input rv_instr_pkg::rv_instr_u got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_pc(input logic [ib_pkg::PC_W-1:0] got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_valid(input logic [ib_pkg::IB_DEPTH-1:0] got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic push_entry(input rv_instr_pkg::rv_instr_u inst,
                             input logic [ib_pkg::PC_W-1:0] pc,
                             input logic pc4, dbg, wd, fn);
      m_inst.push_back(inst);
      m_pc.push_back(pc);
      m_pc4.push_back(pc4);
      m_dbg.push_back(dbg);
      m_wd.push_back(wd);
      m_fn.push_back(fn);
   endtask

   task automatic pop_entry();
      void'(m_inst.pop_front());
      void'(m_pc.pop_front());
      void'(m_pc4.pop_front());
      void'(m_dbg.pop_front());
      void'(m_wd.pop_front());
      void'(m_fn.pop_front());
   endtask

   // runs at the edge and reads the inputs the DUT samples there
   task automatic update_model();
      int cnt;
      cnt = m_inst.size();
      if (m_fq) begin
         while (m_inst.size() > 0) pop_entry();
      end else begin
         if (dec_i0_decode) pop_entry();
         if (dec_i1_decode) pop_entry();
         if (dbg_cmd_valid && dbg_cmd_type < 2'd2) begin
            push_entry(dbg_word(dbg_cmd_write, dbg_cmd_type, dbg_cmd_addr), '0, 1'b0, 1'b1,
                       dbg_cmd_write, dbg_cmd_write && dbg_cmd_type == rv_instr_pkg::DBG_TYPE_CSR
                       && dbg_cmd_addr == rv_instr_pkg::CSR_DEBUG_FENCE);
         end
         if (ifu_i0_valid && cnt < 4) begin
            push_entry(ifu_i0_inst, ifu_i0_pc, ifu_i0_pc4, 1'b0, 1'b0, 1'b0);
            next_seq++;
         end
         if (ifu_i1_valid && cnt < 3) begin
            push_entry(ifu_i1_inst, ifu_i1_pc, ifu_i1_pc4, 1'b0, 1'b0, 1'b0);
            next_seq++;
         end
      end
      m_fq = flush;
   endtask

   task automatic compare_state();
      logic [ib_pkg::IB_DEPTH-1:0] ev;
      ev = '0;
      for (int k = 0; k < m_inst.size(); k++) ev[k] = 1'b1;
      check_valid(ib_valid, ev, "ib_valid");
      if (m_inst.size() > 0) begin
         check_inst(i0_inst, m_inst[0], "i0_inst");
         check_pc(i0_pc, m_pc[0], "i0_pc");
         check_flag(i0_pc4, m_pc4[0], "i0_pc4");
         check_flag(i0_debug_valid, m_dbg[0], "i0_debug_valid");
         check_flag(debug_wdata_rs1, m_wd[0], "debug_wdata_rs1");
         check_flag(debug_fence, m_fn[0], "debug_fence");
      end else begin
         check_flag(i0_debug_valid, 1'b0, "i0_debug_valid while empty");
      end
      if (m_inst.size() > 1) begin
         check_inst(i1_inst, m_inst[1], "i1_inst");
         check_pc(i1_pc, m_pc[1], "i1_pc");
         check_flag(i1_pc4, m_pc4[1], "i1_pc4");
      end
   endtask

   // all status outputs low straight out of reset
   task automatic verify_reset_state();
      @(negedge clk);
      check_valid(ib_valid, '0, "ib_valid after reset");
      check_flag(debug_wdata_rs1, 1'b0, "debug_wdata_rs1 after reset");
      check_flag(debug_fence, 1'b0, "debug_fence after reset");
      check_flag(i0_debug_valid, 1'b0, "i0_debug_valid after reset");
   endtask

   // one cycle of aligner and decode traffic; decode is trimmed to what is valid
   task automatic step(input logic i0, i1, d0, d1, fl);
      logic dd0;
      logic dd1;
      @(posedge clk);
      update_model();
      dd0 = d0 && m_inst.size() > 0;
      dd1 = d1 && dd0 && m_inst.size() > 1;
      ifu_i0_valid <= i0;
      ifu_i0_inst <= seq_inst(next_seq);
      ifu_i0_pc <= seq_pc(next_seq);
      ifu_i0_pc4 <= next_seq[0];
      ifu_i1_valid <= i0 & i1;
      ifu_i1_inst <= seq_inst(next_seq + 1);
      ifu_i1_pc <= seq_pc(next_seq + 1);
      ifu_i1_pc4 <= ~next_seq[0];
      dec_i0_decode <= dd0;
      dec_i1_decode <= dd1;
      flush <= fl;
      dbg_cmd_valid <= 1'b0;
      @(negedge clk);
      compare_state();
   endtask

   // debug command with aligner idle and no decode
   task automatic dbg_step(input logic wr, input logic [1:0] typ, input logic [11:0] addr);
      @(posedge clk);
      update_model();
      ifu_i0_valid <= 1'b0;
      ifu_i1_valid <= 1'b0;
      dec_i0_decode <= 1'b0;
      dec_i1_decode <= 1'b0;
      flush <= 1'b0;
      dbg_cmd_valid <= 1'b1;
      dbg_cmd_write <= wr;
      dbg_cmd_type <= typ;
      dbg_cmd_addr <= addr;
      @(negedge clk);
      compare_state();
   endtask

   task automatic drain();
      repeat (4) step(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
   endtask

   task automatic fill_and_drain();
      step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      step(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      step(1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
      step(1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
      step(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      step(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
      drain();
   endtask

   task automatic refuse_when_full();
      step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      repeat (3) step(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);   // i1 refused at three, both at four
      step(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      step(1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
      step(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      drain();
      drain();
   endtask

   task automatic flush_pulse();
      step(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      step(1'b1, 1'b1, 1'b0, 1'b0, 1'b1);   // accepted with the pulse and then lost
      step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);   // blocked by flush_q
      step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      check_valid(ib_valid, '0, "ib_valid after flush");
      step(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      drain();
   endtask

   task automatic gpr_debug_cmds();
      dbg_step(1'b0, rv_instr_pkg::DBG_TYPE_GPR, 12'd5);
      step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      dbg_step(1'b1, rv_instr_pkg::DBG_TYPE_GPR, 12'd17);
      step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      step(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);   // normal entry replaces the debug one
      step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      drain();
   endtask

   task automatic csr_debug_cmds();
      dbg_step(1'b0, rv_instr_pkg::DBG_TYPE_CSR, 12'h300);
      step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      dbg_step(1'b1, rv_instr_pkg::DBG_TYPE_CSR, rv_instr_pkg::CSR_DEBUG_FENCE);
      step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      dbg_step(1'b1, rv_instr_pkg::DBG_TYPE_CSR, 12'h305);
      step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
      dbg_step(1'b1, 2'd2, 12'h010);   // memory type is ignored
      step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      check_valid(ib_valid, '0, "ib_valid after type 2 command");
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      repeat (RANDOM_STEPS) begin
         r = $random(seed);
         step(r[0], r[1], r[2], r[3], r[8:4] == 5'd0);
      end
      step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      drain();
   endtask

   initial begin
      seed = 32'h2662d6ab;
      errors = 0;
      checks = 0;
      cycles = 0;
      next_seq = 1;
      m_fq = 1'b0;
      rst_n = 1'b0;
      ifu_i0_valid = 1'b0;
      ifu_i0_inst = '0;
      ifu_i0_pc = '0;
      ifu_i0_pc4 = 1'b0;
      ifu_i1_valid = 1'b0;
      ifu_i1_inst = '0;
      ifu_i1_pc = '0;
      ifu_i1_pc4 = 1'b0;
      dec_i0_decode = 1'b0;
      dec_i1_decode = 1'b0;
      flush = 1'b0;
      dbg_cmd_valid = 1'b0;
      dbg_cmd_write = 1'b0;
      dbg_cmd_type = '0;
      dbg_cmd_addr = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      verify_reset_state();
      fill_and_drain();
      refuse_when_full();
      flush_pulse();
      gpr_debug_cmds();
      csr_debug_cmds();
      random_traffic();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: src.f
verilog/ib_pkg.sv
verilog/rv_instr_pkg.sv
verilog/ib_ctl_if.sv
verilog/dbg_inj_if.sv
verilog/dbg_instr_gen.sv
verilog/ib_ctl.sv
verilog/ib_entries.sv
verilog/dbg_status.sv
verilog/ib_top.sv
tb/tb_ib_properties.sv
tb/tb_ib_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_ib_top -o sim_ib

if ! ./obj_dir/sim_ib > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
